// ==== list.f ====
source/ptw_pkg.sv
source/miss_select.sv
source/pte_check.sv
source/pmp_check.sv
source/ptw_walker.sv
source/ptw_top.sv
test/ptw_chk.sv
test/tb_ptw.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ptw testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f list.f --top-module tb_ptw -o tb_ptw_sim \
  > build.log 2>&1 &&
  ./obj_dir/tb_ptw_sim > sim.log 2>&1 ||
  echo "build or simulation stopped with an error"
grep -q "Verification passed" sim.log && echo "PASS" && exit 0 ||
  { echo "FAIL, see build.log and sim.log"; exit 1; }

// ==== test/tb_ptw.sv ====
module tb_ptw
  import ptw_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  // ----------------------------------------
  // stimulus table layout
  // ----------------------------------------
  localparam logic [1:0] P_I = 2'd0;
  localparam logic [1:0] P_D = 2'd1;
  localparam logic [1:0] P_BOTH = 2'd2;
  localparam logic [1:0] O_UPD = 2'd0;
  localparam logic [1:0] O_PF = 2'd1;
  localparam logic [1:0] O_AF = 2'd2;
  localparam logic [1:0] O_NONE = 2'd3;
  localparam int TIMEOUT = 200;
  // root table at 0x8000_0000, then one table per level
  localparam logic [PPNW-1:0] ROOT_PPN = 44'h80000;

  typedef struct packed {
    logic [1:0]      port;
    logic [VLEN-1:0] vaddr;
    logic            store;
    logic            mxr;
    logic            deny;
    int              flush_at;
    logic [1:0]      outcome;
    logic [PPNW-1:0] ppn;
    logic            is_2m;
    logic            is_1g;
    logic            g;
  } row_t;

  logic clk_i;
  logic rst_ni;
  logic itlb_access_i;
  logic itlb_hit_i;
  logic [VLEN-1:0] itlb_vaddr_i;
  logic dtlb_access_i;
  logic dtlb_hit_i;
  logic [VLEN-1:0] dtlb_vaddr_i;
  logic enable_translation_i;
  logic en_ld_st_translation_i;
  logic [PPNW-1:0] satp_ppn_i;
  logic [ASID_W-1:0] asid_i;
  logic mxr_i;
  logic lsu_is_store_i;
  logic flush_i;
  pmp_cfg_t [PMP_ENTRIES-1:0] pmpcfg_i;
  logic [PMP_ENTRIES-1:0][PLEN-3:0] pmpaddr_i;
  mem_rsp_t mem_rsp_i;
  mem_req_t mem_req_o;
  tlb_update_t itlb_update_o;
  tlb_update_t dtlb_update_o;
  logic [VLEN-1:0] update_vaddr_o;
  logic ptw_active_o;
  logic walking_instr_o;
  logic ptw_error_o;
  logic ptw_access_exception_o;
  logic [PLEN-1:0] bad_paddr_o;
  logic itlb_miss_o;
  logic dtlb_miss_o;

  // page table image, absent entries read as zero
  logic [63:0] pt_image [logic [PLEN-1:0]];
  row_t rows [$];
  int seed = 32'h5f8e;
  int errors = 0;

  ptw_top u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------
  function automatic logic [VLEN-1:0] va(input logic [8:0] v2, input logic [8:0] v1,
                                         input logic [8:0] v0);
    return {v2, v1, v0, 12'h000};
  endfunction

  // flags are d a g u x w r v, msb first
  function automatic logic [63:0] make_pte(input logic [PPNW-1:0] ppn, input logic [7:0] fl);
    return {10'h000, ppn, 2'b00, fl};
  endfunction

  function automatic logic [PLEN-1:0] entry_addr(input logic [PPNW-1:0] ppn,
                                                 input logic [8:0] idx);
    return {ppn, idx, 3'b000};
  endfunction

  function automatic logic [63:0] read_image(input logic [PLEN-1:0] addr);
    if (pt_image.exists(addr)) begin
      return pt_image[addr];
    end
    return 64'h0;
  endfunction

  // second level pte address, found by reading the root entry
  function automatic logic [PLEN-1:0] l2_addr(input logic [VLEN-1:0] vaddr);
    pte_t root;
    root = pte_t'(read_image(entry_addr(ROOT_PPN, vaddr[38:30])));
    return entry_addr(root.ppn, vaddr[29:21]);
  endfunction

  task automatic compare_hex(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input logic [1:0] port, input logic [VLEN-1:0] vaddr,
                         input logic store, input logic mxr, input logic deny,
                         input int flush_at, input logic [1:0] outcome,
                         input logic [PPNW-1:0] ppn, input logic is_2m,
                         input logic is_1g, input logic g);
    row_t r;
    r = '{port, vaddr, store, mxr, deny, flush_at, outcome, ppn, is_2m, is_1g, g};
    rows.push_back(r);
  endtask

  // ----------------------------------------
  // memory model
  // ----------------------------------------
  initial begin
    int wait_cnt;
    bit owed;
    logic [PLEN-1:0] addr_q;
    mem_rsp_i = '0;
    wait_cnt = -1;
    owed = 1'b0;
    addr_q = '0;
    forever begin
      @(negedge clk_i);
      mem_rsp_i.data_gnt = 1'b0;
      mem_rsp_i.data_rvalid = 1'b0;
      // data follows one cycle after the grant
      if (owed) begin
        mem_rsp_i.data_rvalid = 1'b1;
        mem_rsp_i.data_rdata = read_image(addr_q);
        owed = 1'b0;
      end
      if (mem_req_o.data_req) begin
        if (wait_cnt < 0) begin
          wait_cnt = $unsigned($random(seed)) % 3;
        end
        if (wait_cnt == 0) begin
          mem_rsp_i.data_gnt = 1'b1;
          addr_q = {mem_req_o.address_tag, mem_req_o.address_index};
          owed = 1'b1;
          wait_cnt = -1;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // ----------------------------------------
  // one row, start to idle
  // ----------------------------------------
  task automatic run_row(input row_t r);
    int cyc;
    bit done;
    bit upd_i;
    bit upd_d;
    tlb_update_t upd;
    @(negedge clk_i);
    itlb_access_i = (r.port != P_D);
    itlb_vaddr_i = (r.port == P_I) ? r.vaddr : va(9'd0, 9'd0, 9'd0);
    dtlb_access_i = (r.port != P_I);
    dtlb_vaddr_i = r.vaddr;
    lsu_is_store_i = r.store;
    mxr_i = r.mxr;
    // entry 0 denies the second level table when asked
    pmpcfg_i[0].mode = r.deny ? NAPOT : OFF;
    #1;
    compare_hex("dtlb_miss_o", 64'(dtlb_miss_o), 64'(r.port != P_I));
    compare_hex("itlb_miss_o", 64'(itlb_miss_o), 64'(r.port == P_I));
    cyc = 0;
    done = 1'b0;
    while (!done && cyc < TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
      itlb_access_i = 1'b0;
      dtlb_access_i = 1'b0;
      upd_i = itlb_update_o.valid;
      upd_d = dtlb_update_o.valid;
      if (r.outcome == O_NONE) begin
        assert (!(upd_i || upd_d || ptw_error_o || ptw_access_exception_o)) else begin
          $display("walk produced a result after a flush in cycle %0d", cyc);
          errors++;
        end
        flush_i = 1'b0;
        done = (cyc > r.flush_at) && !ptw_active_o;
        if (cyc == r.flush_at) begin
          flush_i = 1'b1;
        end
      end else if (upd_i || upd_d || ptw_error_o || ptw_access_exception_o) begin
        done = 1'b1;
        compare_hex("itlb_update_o.valid", 64'(upd_i),
                    64'(r.outcome == O_UPD && r.port == P_I));
        compare_hex("dtlb_update_o.valid", 64'(upd_d),
                    64'(r.outcome == O_UPD && r.port != P_I));
        compare_hex("ptw_error_o", 64'(ptw_error_o), 64'(r.outcome == O_PF));
        compare_hex("ptw_access_exception_o", 64'(ptw_access_exception_o),
                    64'(r.outcome == O_AF));
        compare_hex("walking_instr_o", 64'(walking_instr_o), 64'(r.port == P_I));
        if (r.outcome == O_UPD) begin
          upd = upd_i ? itlb_update_o : dtlb_update_o;
          compare_hex("update.vpn", 64'(upd.vpn), 64'(r.vaddr[38:12]));
          compare_hex("update.asid", 64'(upd.asid), 64'(asid_i));
          compare_hex("update.content.ppn", 64'(upd.content.ppn), 64'(r.ppn));
          compare_hex("update.is_2m", 64'(upd.is_2m), 64'(r.is_2m));
          compare_hex("update.is_1g", 64'(upd.is_1g), 64'(r.is_1g));
          compare_hex("update.content.g", 64'(upd.content.g), 64'(r.g));
          compare_hex("update_vaddr_o", 64'(update_vaddr_o), 64'(r.vaddr));
        end
        if (r.outcome == O_AF) begin
          compare_hex("bad_paddr_o", 64'(bad_paddr_o), 64'(l2_addr(r.vaddr)));
        end
      end
    end
    if (!done) begin
      $display("timeout: walk for vaddr %h gave no result", r.vaddr);
      errors++;
    end
    // walker must drop back to idle
    cyc = 0;
    while (ptw_active_o && cyc < TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (ptw_active_o) begin
      $display("timeout: ptw_active_o stayed high after the walk");
      errors++;
    end
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    int err_before;
    rst_ni = 1'b0;
    itlb_access_i = 1'b0;
    itlb_hit_i = 1'b0;
    itlb_vaddr_i = '0;
    dtlb_access_i = 1'b0;
    dtlb_hit_i = 1'b0;
    dtlb_vaddr_i = '0;
    enable_translation_i = 1'b1;
    en_ld_st_translation_i = 1'b1;
    satp_ppn_i = ROOT_PPN;
    asid_i = 16'h00a5;
    mxr_i = 1'b0;
    lsu_is_store_i = 1'b0;
    flush_i = 1'b0;
    pmpcfg_i[0] = '{r: 1'b0, w: 1'b0, x: 1'b0, mode: OFF};
    pmpcfg_i[1] = '{r: 1'b1, w: 1'b0, x: 1'b0, mode: NAPOT};
    pmpcfg_i[2] = '{r: 1'b0, w: 1'b0, x: 1'b0, mode: OFF};
    pmpcfg_i[3] = '{r: 1'b0, w: 1'b0, x: 1'b0, mode: OFF};
    // 4K over the second level table, 16K over all tables
    pmpaddr_i[0] = 54'h2000_05ff;
    pmpaddr_i[1] = 54'h2000_07ff;
    pmpaddr_i[2] = '0;
    pmpaddr_i[3] = '0;

    // root table
    pt_image[entry_addr(ROOT_PPN, 9'd0)] = make_pte(44'h80001, 8'h01);
    pt_image[entry_addr(ROOT_PPN, 9'd1)] = make_pte(44'h80001, 8'h21);
    pt_image[entry_addr(ROOT_PPN, 9'd2)] = make_pte(44'hc0000, 8'hc7);
    pt_image[entry_addr(ROOT_PPN, 9'd3)] = make_pte(44'hc0001, 8'hc7);
    // second level
    pt_image[entry_addr(44'h80001, 9'd0)] = make_pte(44'h80002, 8'h01);
    pt_image[entry_addr(44'h80001, 9'd1)] = make_pte(44'h01200, 8'hc7);
    pt_image[entry_addr(44'h80001, 9'd2)] = make_pte(44'h00000, 8'h05);
    // third level
    pt_image[entry_addr(44'h80002, 9'd0)] = make_pte(44'h12345, 8'h49);
    pt_image[entry_addr(44'h80002, 9'd1)] = make_pte(44'h23456, 8'h47);
    pt_image[entry_addr(44'h80002, 9'd2)] = make_pte(44'h80002, 8'h01);
    pt_image[entry_addr(44'h80002, 9'd3)] = make_pte(44'h34567, 8'h49);
    pt_image[entry_addr(44'h80002, 9'd4)] = make_pte(44'h45678, 8'h43);
    pt_image[entry_addr(44'h80002, 9'd5)] = make_pte(44'h55555, 8'hc7);

    // port, vaddr, store, mxr, deny, flush, outcome, ppn, 2m, 1g, g
    add_row(P_I, va(9'd1, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'h12345, 1'b0, 1'b0, 1'b1);
    add_row(P_I, va(9'd0, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'h12345, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd1, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'h01200, 1'b1, 1'b0, 1'b0);
    add_row(P_D, va(9'd2, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'hc0000, 1'b0, 1'b1, 1'b0);
    add_row(P_D, va(9'd3, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd4, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd2, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_I, va(9'd0, 9'd0, 9'd4), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd1), 1'b1, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd2), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd3), 1'b0, 1'b0, 1'b0, 0, O_PF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd3), 1'b0, 1'b1, 1'b0, 0, O_UPD, 44'h34567, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd5), 1'b0, 1'b0, 1'b1, 0, O_AF, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_BOTH, va(9'd0, 9'd0, 9'd5), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'h55555, 1'b0, 1'b0, 1'b0);
    add_row(P_I, va(9'd0, 9'd0, 9'd0), 1'b0, 1'b0, 1'b0, 0, O_UPD, 44'h12345, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd5), 1'b0, 1'b0, 1'b0, 3, O_NONE, 44'h0, 1'b0, 1'b0, 1'b0);
    add_row(P_D, va(9'd0, 9'd0, 9'd5), 1'b1, 1'b0, 1'b0, 0, O_UPD, 44'h55555, 1'b0, 1'b0, 1'b0);

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    compare_hex("ptw_active_o", 64'(ptw_active_o), 64'h0);

    foreach (rows[i]) begin
      err_before = errors;
      run_row(rows[i]);
      $display("row %0d vaddr %h: %s", i, rows[i].vaddr,
               (errors == err_before) ? "ok" : "FAIL");
    end
    errors = errors + u_dut.u_walker.u_chk.fail_count;
    $display("rows run %0d, checks in error %0d", rows.size(), errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== test/ptw_chk.sv ====
module ptw_chk
  import ptw_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input mem_req_t    mem_req_o,
  input mem_rsp_t    mem_rsp_i,
  input tlb_update_t itlb_update_o,
  input tlb_update_t dtlb_update_o,
  input logic        ptw_error_o,
  input logic        ptw_access_exception_o,
  input logic        ptw_active_o
);

  timeunit 1ns;
  timeprecision 1ps;

  logic upd;
  logic err;
  // number of failed assertions
  int   fail_count = 0;

  assign upd = itlb_update_o.valid | dtlb_update_o.valid;
  assign err = ptw_error_o | ptw_access_exception_o;

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  // request is never withdrawn before the grant
  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.data_req && !mem_rsp_i.data_gnt |=> mem_req_o.data_req)
    else begin
      $error("data_req dropped without a grant");
      fail_count++;
    end

  // tag strobe only right after a grant
  tag_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o.tag_valid |-> $past(mem_req_o.data_req && mem_rsp_i.data_gnt))
    else begin
      $error("tag_valid without a grant in the cycle before");
      fail_count++;
    end

  // ----------------------------------------
  // results
  // ----------------------------------------
  one_result: assert property (@(posedge clk_i) disable iff (!rst_ni) !(upd && err))
    else begin
      $error("update and error in the same cycle");
      fail_count++;
    end

  idle_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !ptw_active_o)
    else begin
      $error("ptw_active_o high during reset");
      fail_count++;
    end

endmodule

bind ptw_walker ptw_chk u_chk (
  .clk_i                  (clk_i),
  .rst_ni                 (rst_ni),
  .mem_req_o              (mem_req_o),
  .mem_rsp_i              (mem_rsp_i),
  .itlb_update_o          (itlb_update_o),
  .dtlb_update_o          (dtlb_update_o),
  .ptw_error_o            (ptw_error_o),
  .ptw_access_exception_o (ptw_access_exception_o),
  .ptw_active_o           (ptw_active_o)
);

// ==== source/ptw_top.sv ====
module ptw_top
  import ptw_pkg::*;
(
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // tlb side
  input  logic                             itlb_access_i,
  input  logic                             itlb_hit_i,
  input  logic [VLEN-1:0]                  itlb_vaddr_i,
  input  logic                             dtlb_access_i,
  input  logic                             dtlb_hit_i,
  input  logic [VLEN-1:0]                  dtlb_vaddr_i,
  // control and status
  input  logic                             enable_translation_i,
  input  logic                             en_ld_st_translation_i,
  input  logic [PPNW-1:0]                  satp_ppn_i,
  input  logic [ASID_W-1:0]                asid_i,
  input  logic                             mxr_i,
  input  logic                             lsu_is_store_i,
  input  logic                             flush_i,
  // pmp
  input  pmp_cfg_t [PMP_ENTRIES-1:0]       pmpcfg_i,
  input  logic [PMP_ENTRIES-1:0][PLEN-3:0] pmpaddr_i,
  // memory
  input  mem_rsp_t                         mem_rsp_i,
  output mem_req_t                         mem_req_o,
  // results
  output tlb_update_t                      itlb_update_o,
  output tlb_update_t                      dtlb_update_o,
  output logic [VLEN-1:0]                  update_vaddr_o,
  output logic                             ptw_active_o,
  output logic                             walking_instr_o,
  output logic                             ptw_error_o,
  output logic                             ptw_access_exception_o,
  output logic [PLEN-1:0]                  bad_paddr_o,
  output logic                             itlb_miss_o,
  output logic                             dtlb_miss_o
);

  walk_req_t       walk_req;
  logic            idle;
  pte_t            pte;
  ptw_lvl_e        lvl;
  logic            is_instr;
  logic            is_store;
  pte_verdict_e    verdict;
  logic [PLEN-1:0] pptr;
  logic            allow;

  miss_select u_miss_select (
    .itlb_access_i          (itlb_access_i),
    .itlb_hit_i             (itlb_hit_i),
    .itlb_vaddr_i           (itlb_vaddr_i),
    .dtlb_access_i          (dtlb_access_i),
    .dtlb_hit_i             (dtlb_hit_i),
    .dtlb_vaddr_i           (dtlb_vaddr_i),
    .enable_translation_i   (enable_translation_i),
    .en_ld_st_translation_i (en_ld_st_translation_i),
    .satp_ppn_i             (satp_ppn_i),
    .asid_i                 (asid_i),
    .idle_i                 (idle),
    .walk_req_o             (walk_req),
    .itlb_miss_o            (itlb_miss_o),
    .dtlb_miss_o            (dtlb_miss_o)
  );

  ptw_walker u_walker (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .flush_i                (flush_i),
    .walk_req_i             (walk_req),
    .mem_rsp_i              (mem_rsp_i),
    .verdict_i              (verdict),
    .allow_i                (allow),
    .lsu_is_store_i         (lsu_is_store_i),
    .mem_req_o              (mem_req_o),
    .pte_o                  (pte),
    .lvl_o                  (lvl),
    .is_instr_o             (is_instr),
    .is_store_o             (is_store),
    .pptr_o                 (pptr),
    .idle_o                 (idle),
    .itlb_update_o          (itlb_update_o),
    .dtlb_update_o          (dtlb_update_o),
    .update_vaddr_o         (update_vaddr_o),
    .ptw_active_o           (ptw_active_o),
    .walking_instr_o        (walking_instr_o),
    .ptw_error_o            (ptw_error_o),
    .ptw_access_exception_o (ptw_access_exception_o),
    .bad_paddr_o            (bad_paddr_o)
  );

  pte_check u_pte_check (
    .pte_i      (pte),
    .lvl_i      (lvl),
    .is_instr_i (is_instr),
    .is_store_i (is_store),
    .mxr_i      (mxr_i),
    .verdict_o  (verdict)
  );

  // pte fetches are checked as s-mode reads
  pmp_check u_pmp_check (
    .addr_i    (pptr),
    .cfg_i     (pmpcfg_i),
    .pmpaddr_i (pmpaddr_i),
    .allow_o   (allow)
  );

endmodule

// ==== source/ptw_walker.sv ====
module ptw_walker
  import ptw_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            flush_i,
  input  walk_req_t       walk_req_i,
  input  mem_rsp_t        mem_rsp_i,
  input  pte_verdict_e    verdict_i,
  input  logic            allow_i,
  input  logic            lsu_is_store_i,
  output mem_req_t        mem_req_o,
  output pte_t            pte_o,
  output ptw_lvl_e        lvl_o,
  output logic            is_instr_o,
  output logic            is_store_o,
  output logic [PLEN-1:0] pptr_o,
  output logic            idle_o,
  output tlb_update_t     itlb_update_o,
  output tlb_update_t     dtlb_update_o,
  output logic [VLEN-1:0] update_vaddr_o,
  output logic            ptw_active_o,
  output logic            walking_instr_o,
  output logic            ptw_error_o,
  output logic            ptw_access_exception_o,
  output logic [PLEN-1:0] bad_paddr_o
);

  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    WAIT_RVALID,
    PROPAGATE_ERROR,
    PROPAGATE_ACCESS_ERROR
  } state_e;

  state_e            state_q, state_d;
  ptw_lvl_e          lvl_q, lvl_d;
  logic              is_instr_q, is_instr_d;
  // g seen anywhere on the path
  logic              global_q, global_d;
  logic              tag_valid_q, tag_valid_d;
  // walk was flushed while a grant or data is owed
  logic              abandon_q, abandon_d;
  // registered memory response
  logic              data_rvalid_q;
  logic [63:0]       data_rdata_q;
  logic [ASID_W-1:0] asid_q, asid_d;
  logic [VLEN-1:0]   vaddr_q, vaddr_d;
  // address of the pte being fetched
  logic [PLEN-1:0]   pptr_q, pptr_d;
  pte_t              pte;
  logic [VPN_W-1:0]  vpn_slice;
  logic              update_valid;
  tlb_update_t       update;

  assign pte = pte_t'(data_rdata_q);

  // vaddr slice for the level below the current one
  assign vpn_slice = (lvl_q == LVL1) ? vaddr_q[29:21] : vaddr_q[20:12];

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  // request held in WAIT_GRANT until granted
  assign mem_req_o.data_req      = (state_q == WAIT_GRANT);
  assign mem_req_o.tag_valid     = tag_valid_q;
  assign mem_req_o.address_index = pptr_q[DCACHE_INDEX_W-1:0];
  assign mem_req_o.address_tag   = pptr_q[DCACHE_INDEX_W+DCACHE_TAG_W-1:DCACHE_INDEX_W];

  // to pte and pmp checks
  assign pte_o      = pte;
  assign lvl_o      = lvl_q;
  assign is_instr_o = is_instr_q;
  // only data walks carry the store check
  assign is_store_o = lsu_is_store_i & ~is_instr_q;
  assign pptr_o     = pptr_q;
  // no new walk in a flush cycle
  assign idle_o     = (state_q == IDLE) & ~flush_i;

  // status and error pulses
  assign update_vaddr_o         = vaddr_q;
  assign ptw_active_o           = (state_q != IDLE);
  assign walking_instr_o        = is_instr_q;
  assign ptw_error_o            = (state_q == PROPAGATE_ERROR) & ~flush_i;
  assign ptw_access_exception_o = (state_q == PROPAGATE_ACCESS_ERROR) & ~flush_i;
  // failing pte address only during the access fault
  assign bad_paddr_o            = ptw_access_exception_o ? pptr_q : '0;

  // ----------------------------------------
  // tlb update
  // ----------------------------------------
  always_comb begin
    update.valid     = 1'b0;
    update.vpn       = vaddr_q[38:12];
    update.asid      = asid_q;
    update.is_2m     = (lvl_q == LVL2);
    update.is_1g     = (lvl_q == LVL1);
    update.content   = pte;
    // fold in the global bit of the upper levels
    update.content.g = pte.g | global_q;

    itlb_update_o       = update;
    itlb_update_o.valid = update_valid & is_instr_q;
    dtlb_update_o       = update;
    dtlb_update_o.valid = update_valid & ~is_instr_q;
  end

  // ----------------------------------------
  // walk fsm
  // ----------------------------------------
  always_comb begin
    state_d      = state_q;
    lvl_d        = lvl_q;
    is_instr_d   = is_instr_q;
    global_d     = global_q;
    tag_valid_d  = 1'b0;
    abandon_d    = abandon_q;
    asid_d       = asid_q;
    vaddr_d      = vaddr_q;
    pptr_d       = pptr_q;
    update_valid = 1'b0;

    unique case (state_q)
      IDLE: begin
        // every walk starts at the root table
        lvl_d     = LVL1;
        global_d  = 1'b0;
        abandon_d = 1'b0;
        if (walk_req_i.valid) begin
          is_instr_d = walk_req_i.is_instr;
          asid_d     = walk_req_i.asid;
          vaddr_d    = walk_req_i.vaddr;
          pptr_d     = {walk_req_i.root_ppn, walk_req_i.vaddr[38:30], 3'b000};
          state_d    = WAIT_GRANT;
        end
      end
      WAIT_GRANT: begin
        if (mem_rsp_i.data_gnt) begin
          // tag follows one cycle after grant
          tag_valid_d = 1'b1;
          state_d     = abandon_q ? WAIT_RVALID : PTE_LOOKUP;
        end
      end
      PTE_LOOKUP: begin
        if (data_rvalid_q) begin
          global_d = global_q | pte.g;
          if (!allow_i) begin
            // pptr kept for bad_paddr_o
            state_d = PROPAGATE_ACCESS_ERROR;
          end else begin
            unique case (verdict_i)
              PTE_LEAF: begin
                update_valid = 1'b1;
                state_d      = IDLE;
              end
              PTE_POINTER: begin
                lvl_d   = (lvl_q == LVL1) ? LVL2 : LVL3;
                pptr_d  = {pte.ppn, vpn_slice, 3'b000};
                state_d = WAIT_GRANT;
              end
              default: begin
                state_d = PROPAGATE_ERROR;
              end
            endcase
          end
        end
      end
      WAIT_RVALID: begin
        if (data_rvalid_q) begin
          state_d = IDLE;
        end
      end
      // error states pulse for one cycle
      default: begin
        state_d = IDLE;
      end
    endcase

    // flush drops the walk but settles any owed grant or data
    if (flush_i) begin
      update_valid = 1'b0;
      unique case (state_q)
        WAIT_GRANT: begin
          abandon_d = 1'b1;
          state_d   = mem_rsp_i.data_gnt ? WAIT_RVALID : WAIT_GRANT;
        end
        PTE_LOOKUP, WAIT_RVALID: begin
          state_d = data_rvalid_q ? IDLE : WAIT_RVALID;
        end
        default: begin
          state_d = IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------
  // registers
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= IDLE;
      lvl_q         <= LVL1;
      is_instr_q    <= 1'b0;
      global_q      <= 1'b0;
      tag_valid_q   <= 1'b0;
      abandon_q     <= 1'b0;
      data_rvalid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      lvl_q         <= lvl_d;
      is_instr_q    <= is_instr_d;
      global_q      <= global_d;
      tag_valid_q   <= tag_valid_d;
      abandon_q     <= abandon_d;
      data_rvalid_q <= mem_rsp_i.data_rvalid;
    end
  end

  // walk payload
  always_ff @(posedge clk_i) begin
    data_rdata_q <= mem_rsp_i.data_rdata;
    asid_q       <= asid_d;
    vaddr_q      <= vaddr_d;
    pptr_q       <= pptr_d;
  end

endmodule

// ==== source/pmp_check.sv ====
module pmp_check
  import ptw_pkg::*;
(
  input  logic [PLEN-1:0]                     addr_i,
  input  pmp_cfg_t [PMP_ENTRIES-1:0]          cfg_i,
  input  logic [PMP_ENTRIES-1:0][PLEN-3:0]    pmpaddr_i,
  output logic                                allow_o
);

  logic [PMP_ENTRIES-1:0] match;

  // ----------------------------------------
  // per entry address match
  // ----------------------------------------
  always_comb begin
    logic [PLEN-1:0] lower;
    logic [PLEN-1:0] upper;
    logic [PLEN-3:0] ones;

    // entry 0 tor starts at address zero
    lower = '0;
    for (int i = 0; i < PMP_ENTRIES; i++) begin
      upper = {pmpaddr_i[i], 2'b00};
      // trailing ones plus the next bit set
      ones  = pmpaddr_i[i] ^ (pmpaddr_i[i] + 1'b1);
      unique case (cfg_i[i].mode)
        TOR: begin
          match[i] = (addr_i >= lower) && (addr_i < upper);
        end
        NAPOT: begin
          // region of 2^(k+3) bytes for k trailing ones
          match[i] = ((addr_i ^ upper) & ~{ones, 2'b11}) == '0;
        end
        default: begin
          match[i] = 1'b0;
        end
      endcase
      // next tor entry starts here
      lower = upper;
    end
  end

  // ----------------------------------------
  // priority, lowest entry wins
  // ----------------------------------------
  always_comb begin
    // s-mode read with no match is denied
    allow_o = 1'b0;
    for (int i = PMP_ENTRIES - 1; i >= 0; i--) begin
      if (match[i]) begin
        allow_o = cfg_i[i].r;
      end
    end
  end

endmodule

// ==== source/pte_check.sv ====
module pte_check
  import ptw_pkg::*;
(
  input  pte_t         pte_i,
  input  ptw_lvl_e     lvl_i,
  input  logic         is_instr_i,
  input  logic         is_store_i,
  input  logic         mxr_i,
  output pte_verdict_e verdict_o
);

  logic is_leaf;
  logic misaligned;

  // r or x marks a leaf, otherwise a pointer
  assign is_leaf = pte_i.r | pte_i.x;

  // superpage ppn must have its low bits clear
  assign misaligned = ((lvl_i == LVL1) && (pte_i.ppn[17:0] != '0)) ||
                      ((lvl_i == LVL2) && (pte_i.ppn[8:0] != '0));

  always_comb begin
    verdict_o = is_leaf ? PTE_LEAF : PTE_POINTER;

    if (!pte_i.v || (!pte_i.r && pte_i.w)) begin
      // invalid or write-only
      verdict_o = PTE_FAULT;
    end else if (is_leaf) begin
      if (is_instr_i) begin
        // fetch needs x and the accessed flag
        if (!pte_i.x || !pte_i.a) begin
          verdict_o = PTE_FAULT;
        end
      end else begin
        // load needs r, or x together with mxr
        if (!pte_i.a || !(pte_i.r || (pte_i.x && mxr_i))) begin
          verdict_o = PTE_FAULT;
        end
        // store also needs w and dirty
        if (is_store_i && (!pte_i.w || !pte_i.d)) begin
          verdict_o = PTE_FAULT;
        end
      end
      if (misaligned) begin
        verdict_o = PTE_FAULT;
      end
    end else begin
      // a, d, u are reserved on pointers
      if (pte_i.a || pte_i.d || pte_i.u) begin
        verdict_o = PTE_FAULT;
      end
      // no level below LVL3
      if (lvl_i == LVL3) begin
        verdict_o = PTE_FAULT;
      end
    end
  end

endmodule

// ==== source/miss_select.sv ====
module miss_select
  import ptw_pkg::*;
(
  input  logic              itlb_access_i,
  input  logic              itlb_hit_i,
  input  logic [VLEN-1:0]   itlb_vaddr_i,
  input  logic              dtlb_access_i,
  input  logic              dtlb_hit_i,
  input  logic [VLEN-1:0]   dtlb_vaddr_i,
  input  logic              enable_translation_i,
  input  logic              en_ld_st_translation_i,
  input  logic [PPNW-1:0]   satp_ppn_i,
  input  logic [ASID_W-1:0] asid_i,
  input  logic              idle_i,
  output walk_req_t         walk_req_o,
  output logic              itlb_miss_o,
  output logic              dtlb_miss_o
);

  logic dtlb_miss;
  logic itlb_miss;

  // data side misses whenever load/store translation is on
  assign dtlb_miss = en_ld_st_translation_i & dtlb_access_i & ~dtlb_hit_i;

  // fetch miss only counts in a cycle without any data access
  assign itlb_miss = enable_translation_i & itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;

  // strobes only while the walker can take the request
  assign dtlb_miss_o = idle_i & dtlb_miss;
  assign itlb_miss_o = idle_i & itlb_miss & ~dtlb_miss;

  always_comb begin
    walk_req_o.valid    = dtlb_miss_o | itlb_miss_o;
    // data miss has priority
    walk_req_o.is_instr = ~dtlb_miss;
    walk_req_o.vaddr    = dtlb_miss ? dtlb_vaddr_i : itlb_vaddr_i;
    walk_req_o.asid     = asid_i;
    // walk always starts at the satp root
    walk_req_o.root_ppn = satp_ppn_i;
  end

endmodule

// ==== source/ptw_pkg.sv ====
package ptw_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  // sv39 virtual address
  localparam int unsigned VLEN = 39;
  // physical address and page number
  localparam int unsigned PLEN = 56;
  localparam int unsigned PPNW = 44;
  localparam int unsigned PAGE_OFFSET_W = 12;
  // one vpn slice per level
  localparam int unsigned VPN_W = 9;
  localparam int unsigned ASID_W = 16;
  // index and tag together cover the whole physical address
  localparam int unsigned DCACHE_INDEX_W = 12;
  localparam int unsigned DCACHE_TAG_W = 44;
  localparam int unsigned PMP_ENTRIES = 4;

  // ----------------------------------------
  // page table types
  // ----------------------------------------
  // walk level, LVL1 maps 1G, LVL2 2M, LVL3 4K
  typedef enum logic [1:0] {
    LVL1,
    LVL2,
    LVL3
  } ptw_lvl_e;

  // sv39 pte, msb first
  typedef struct packed {
    logic [9:0]      reserved;
    logic [PPNW-1:0] ppn;
    logic [1:0]      rsw;
    logic            d;
    logic            a;
    logic            g;
    logic            u;
    logic            x;
    logic            w;
    logic            r;
    logic            v;
  } pte_t;

  // outcome of one pte lookup
  typedef enum logic [1:0] {
    PTE_POINTER,
    PTE_LEAF,
    PTE_FAULT
  } pte_verdict_e;

  // one walk request from the miss selection
  typedef struct packed {
    logic              valid;
    logic [VLEN-1:0]   vaddr;
    logic              is_instr;
    logic [ASID_W-1:0] asid;
    logic [PPNW-1:0]   root_ppn;
  } walk_req_t;

  // ----------------------------------------
  // memory port
  // ----------------------------------------
  typedef struct packed {
    logic                      data_req;
    logic                      tag_valid;
    logic [DCACHE_INDEX_W-1:0] address_index;
    logic [DCACHE_TAG_W-1:0]   address_tag;
  } mem_req_t;

  typedef struct packed {
    logic        data_gnt;
    logic        data_rvalid;
    logic [63:0] data_rdata;
  } mem_rsp_t;

  // tlb fill, vpn is vaddr[38:12]
  typedef struct packed {
    logic              valid;
    logic [26:0]       vpn;
    logic [ASID_W-1:0] asid;
    logic              is_2m;
    logic              is_1g;
    pte_t              content;
  } tlb_update_t;

  // ----------------------------------------
  // pmp
  // ----------------------------------------
  // encoded as the A field of pmpcfg
  typedef enum logic [1:0] {
    OFF   = 2'b00,
    TOR   = 2'b01,
    NAPOT = 2'b11
  } pmp_mode_e;

  typedef struct packed {
    logic      r;
    logic      w;
    logic      x;
    pmp_mode_e mode;
  } pmp_cfg_t;

endpackage
